// File: source/mem_island_defines.svh
/*
 * Memory island sizing macros
 * Address and data widths, bank counts and sub-bank depth
 */

`ifndef MEM_ISLAND_DEFINES_SVH
`define MEM_ISLAND_DEFINES_SVH

// Byte address width
`define MI_ADDR_WIDTH 16
// Port data widths
`define MI_NARROW_WIDTH 32
`define MI_WIDE_WIDTH 64
// Banking: wide banks, and narrow sub-banks inside one wide bank
`define MI_NUM_WIDE_BANKS 2
`define MI_SUB_BANKS (`MI_WIDE_WIDTH / `MI_NARROW_WIDTH)
// Depth of one SRAM sub-bank
`define MI_WORDS_PER_BANK 64

`endif

// File: source/mem_island_types_pkg.sv
/*
 * Memory island vector types
 * Widths for addresses, data, byte strobes and bank indices
 */

`include "mem_island_defines.svh"

package mem_island_types_pkg;

  typedef logic [`MI_ADDR_WIDTH-1:0] addr_t;

  typedef logic [`MI_NARROW_WIDTH-1:0] narrow_data_t;
  typedef logic [`MI_WIDE_WIDTH-1:0] wide_data_t;

  // One enable bit per byte
  typedef logic [`MI_NARROW_WIDTH/8-1:0] narrow_strb_t;
  typedef logic [`MI_WIDE_WIDTH/8-1:0] wide_strb_t;

  typedef logic [$clog2(`MI_WORDS_PER_BANK)-1:0] row_t;

  typedef logic [$clog2(`MI_NUM_WIDE_BANKS)-1:0] wide_bank_t;
  typedef logic [$clog2(`MI_SUB_BANKS)-1:0] sub_bank_t;

endpackage

// File: source/mem_island_bus_pkg.sv
/*
 * Memory island request structs
 * Narrow and wide port requests, and the request seen by one SRAM sub-bank
 */

package mem_island_bus_pkg;

  import mem_island_types_pkg::*;

  // Narrow port request fields, valid while narrow_req_i is high
  typedef struct packed {
    addr_t        addr;
    logic         we;
    narrow_data_t wdata;
    narrow_strb_t strb;
  } narrow_req_t;

  // Wide port request fields
  typedef struct packed {
    addr_t      addr;
    logic       we;
    wide_data_t wdata;
    wide_strb_t strb;
  } wide_req_t;

  // Access to one 32-bit sub-bank, already decoded to a row
  typedef struct packed {
    logic         we;
    row_t         row;
    narrow_data_t wdata;
    narrow_strb_t strb;
  } bank_req_t;

endpackage

// File: source/sram_bank.sv
/*
 * SRAM sub-bank
 * Single-port, byte-enabled, one cycle of read latency
 */

`include "mem_island_defines.svh"

module sram_bank (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,
  input  mem_island_bus_pkg::bank_req_t      bank_i,
  output mem_island_types_pkg::narrow_data_t rdata_o
);

  import mem_island_types_pkg::*;

  narrow_data_t mem_q [`MI_WORDS_PER_BANK];
  narrow_data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (bank_i.we) begin
        for (int b = 0; b < $bits(narrow_strb_t); b++) begin
          if (bank_i.strb[b]) begin
            mem_q[bank_i.row][8*b +: 8] <= bank_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[bank_i.row];
      end
    end
  end

  assign rdata_o = rdata_q;

  // Idle halves of a wide write must not reach the array
  a_write_has_strobe : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (req_i && bank_i.we) |-> (|bank_i.strb)
  ) else $error("sram_bank: write with all-zero strobe");

endmodule

// File: source/bank_arbiter.sv
/*
 * Bank arbiter for one wide bank
 * Narrow traffic has fixed priority, a wide access takes both sub-banks or waits
 */

`include "mem_island_defines.svh"

module bank_arbiter (
  input  logic [`MI_SUB_BANKS-1:0]                          narrow_req_i,
  input  mem_island_bus_pkg::bank_req_t                     narrow_bank_i,
  input  logic                                              wide_req_i,
  input  mem_island_bus_pkg::bank_req_t [`MI_SUB_BANKS-1:0] wide_half_i,
  output logic                                              wide_gnt_o,
  output logic [`MI_SUB_BANKS-1:0]                          sram_req_o,
  output mem_island_bus_pkg::bank_req_t [`MI_SUB_BANKS-1:0] sram_o
);

  logic                     narrow_hit;
  logic [`MI_SUB_BANKS-1:0] wide_half_act;

  // Any narrow access to this bank blocks the whole wide access
  assign narrow_hit = |narrow_req_i;
  assign wide_gnt_o = wide_req_i & ~narrow_hit;

  for (genvar s = 0; s < `MI_SUB_BANKS; s++) begin : gen_sub
    // A write half without enabled bytes leaves its sub-bank idle
    assign wide_half_act[s] = ~wide_half_i[s].we | (|wide_half_i[s].strb);

    assign sram_req_o[s] = narrow_req_i[s] | (wide_gnt_o & wide_half_act[s]);
    assign sram_o[s]     = narrow_req_i[s] ? narrow_bank_i : wide_half_i[s];
  end

  // The narrow port targets a single sub-bank, the mux relies on that
  always_comb begin
    assert ($onehot0(narrow_req_i))
      else $error("bank_arbiter: narrow request to both sub-banks");
  end

endmodule

// File: source/narrow_port.sv
/*
 * Narrow port
 * Decodes a 32-bit request onto one sub-bank and returns its data one cycle later
 */

`include "mem_island_defines.svh"

module narrow_port (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    narrow_req_i,
  input  mem_island_bus_pkg::narrow_req_t         narrow_i,
  output logic                                    narrow_gnt_o,
  output logic                                    narrow_rvalid_o,
  output mem_island_types_pkg::narrow_data_t      narrow_rdata_o,
  output logic [`MI_NUM_WIDE_BANKS-1:0][`MI_SUB_BANKS-1:0] bank_req_o,
  output mem_island_bus_pkg::bank_req_t           bank_o,
  input  mem_island_types_pkg::narrow_data_t [`MI_NUM_WIDE_BANKS-1:0][`MI_SUB_BANKS-1:0]
                                                  bank_rdata_i
);

  import mem_island_types_pkg::*;

  // Address layout: byte, sub-bank, wide bank, row
  localparam int unsigned SubLsb  = $clog2(`MI_NARROW_WIDTH / 8);
  localparam int unsigned BankLsb = SubLsb + $clog2(`MI_SUB_BANKS);
  localparam int unsigned RowLsb  = BankLsb + $clog2(`MI_NUM_WIDE_BANKS);

  wide_bank_t wbank, wbank_q;
  sub_bank_t  sbank, sbank_q;
  logic       rvalid_q;

  assign wbank = narrow_i.addr[BankLsb +: $bits(wide_bank_t)];
  assign sbank = narrow_i.addr[SubLsb +: $bits(sub_bank_t)];

  // Narrow side never waits
  assign narrow_gnt_o = narrow_req_i;

  always_comb begin
    bank_req_o               = '0;
    bank_req_o[wbank][sbank] = narrow_req_i;
  end

  assign bank_o.we    = narrow_i.we;
  assign bank_o.row   = narrow_i.addr[RowLsb +: $bits(row_t)];
  assign bank_o.wdata = narrow_i.wdata;
  assign bank_o.strb  = narrow_i.strb;

  // Remember which sub-bank answers next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      wbank_q  <= '0;
      sbank_q  <= '0;
    end else begin
      rvalid_q <= narrow_req_i;
      if (narrow_req_i) begin
        wbank_q <= wbank;
        sbank_q <= sbank;
      end
    end
  end

  assign narrow_rvalid_o = rvalid_q;
  assign narrow_rdata_o  = bank_rdata_i[wbank_q][sbank_q];

endmodule

// File: source/wide_port.sv
/*
 * Wide port
 * Splits a 64-bit request over the two sub-banks of one wide bank
 * and joins their read words into the wide response
 */

`include "mem_island_defines.svh"

module wide_port (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              wide_req_i,
  input  mem_island_bus_pkg::wide_req_t                     wide_i,
  output logic                                              wide_gnt_o,
  output logic                                              wide_rvalid_o,
  output mem_island_types_pkg::wide_data_t                  wide_rdata_o,
  output logic [`MI_NUM_WIDE_BANKS-1:0]                     bank_req_o,
  output mem_island_bus_pkg::bank_req_t [`MI_SUB_BANKS-1:0] half_o,
  input  logic [`MI_NUM_WIDE_BANKS-1:0]                     bank_gnt_i,
  input  mem_island_types_pkg::narrow_data_t [`MI_NUM_WIDE_BANKS-1:0][`MI_SUB_BANKS-1:0]
                                                            bank_rdata_i
);

  import mem_island_types_pkg::*;

  // Wide words are aligned, so bank select sits right above the wide byte offset
  localparam int unsigned BankLsb = $clog2(`MI_WIDE_WIDTH / 8);
  localparam int unsigned RowLsb  = BankLsb + $clog2(`MI_NUM_WIDE_BANKS);

  wide_bank_t wbank, wbank_q;
  logic       rvalid_q;

  assign wbank = wide_i.addr[BankLsb +: $bits(wide_bank_t)];

  always_comb begin
    bank_req_o        = '0;
    bank_req_o[wbank] = wide_req_i;
  end

  // Low half goes to sub-bank 0, high half to sub-bank 1
  for (genvar s = 0; s < `MI_SUB_BANKS; s++) begin : gen_half
    assign half_o[s].we    = wide_i.we;
    assign half_o[s].row   = wide_i.addr[RowLsb +: $bits(row_t)];
    assign half_o[s].wdata = wide_i.wdata[s*`MI_NARROW_WIDTH +: `MI_NARROW_WIDTH];
    assign half_o[s].strb  = wide_i.strb[s*$bits(narrow_strb_t) +: $bits(narrow_strb_t)];
    assign wide_rdata_o[s*`MI_NARROW_WIDTH +: `MI_NARROW_WIDTH] = bank_rdata_i[wbank_q][s];
  end

  assign wide_gnt_o = bank_gnt_i[wbank];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      wbank_q  <= '0;
    end else begin
      rvalid_q <= wide_req_i & wide_gnt_o;
      if (wide_req_i && wide_gnt_o) begin
        wbank_q <= wbank;
      end
    end
  end

  assign wide_rvalid_o = rvalid_q;

  // A stalled request keeps its fields until it is granted
  a_hold_until_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (wide_req_i && !wide_gnt_o) |=> (wide_req_i && $stable(wide_i))
  ) else $error("wide_port: request changed before grant");

endmodule

// File: source/mem_island_top.sv
/*
 * Memory island top level
 * One narrow and one wide port over two wide banks of two SRAM sub-banks each
 */

`include "mem_island_defines.svh"

module mem_island_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               narrow_req_i,
  input  mem_island_bus_pkg::narrow_req_t    narrow_i,
  output logic                               narrow_gnt_o,
  output logic                               narrow_rvalid_o,
  output mem_island_types_pkg::narrow_data_t narrow_rdata_o,
  input  logic                               wide_req_i,
  input  mem_island_bus_pkg::wide_req_t      wide_i,
  output logic                               wide_gnt_o,
  output logic                               wide_rvalid_o,
  output mem_island_types_pkg::wide_data_t   wide_rdata_o
);

  import mem_island_types_pkg::*;
  import mem_island_bus_pkg::*;

  // Narrow side, one-hot over all sub-banks
  logic [`MI_NUM_WIDE_BANKS-1:0][`MI_SUB_BANKS-1:0] narrow_bank_req;
  bank_req_t                                        narrow_bank;

  // Wide side, one request and grant per wide bank
  logic [`MI_NUM_WIDE_BANKS-1:0]   wide_bank_req;
  logic [`MI_NUM_WIDE_BANKS-1:0]   wide_bank_gnt;
  bank_req_t [`MI_SUB_BANKS-1:0]   wide_half;

  // SRAM side
  logic [`MI_NUM_WIDE_BANKS-1:0][`MI_SUB_BANKS-1:0]         sram_req;
  bank_req_t [`MI_NUM_WIDE_BANKS-1:0][`MI_SUB_BANKS-1:0]    sram;
  narrow_data_t [`MI_NUM_WIDE_BANKS-1:0][`MI_SUB_BANKS-1:0] sram_rdata;

  narrow_port u_narrow_port (
    .clk_i,
    .rst_ni,
    .narrow_req_i,
    .narrow_i,
    .narrow_gnt_o,
    .narrow_rvalid_o,
    .narrow_rdata_o,
    .bank_req_o   (narrow_bank_req),
    .bank_o       (narrow_bank),
    .bank_rdata_i (sram_rdata)
  );

  wide_port u_wide_port (
    .clk_i,
    .rst_ni,
    .wide_req_i,
    .wide_i,
    .wide_gnt_o,
    .wide_rvalid_o,
    .wide_rdata_o,
    .bank_req_o   (wide_bank_req),
    .half_o       (wide_half),
    .bank_gnt_i   (wide_bank_gnt),
    .bank_rdata_i (sram_rdata)
  );

  for (genvar b = 0; b < `MI_NUM_WIDE_BANKS; b++) begin : gen_bank
    bank_arbiter u_bank_arbiter (
      .narrow_req_i  (narrow_bank_req[b]),
      .narrow_bank_i (narrow_bank),
      .wide_req_i    (wide_bank_req[b]),
      .wide_half_i   (wide_half),
      .wide_gnt_o    (wide_bank_gnt[b]),
      .sram_req_o    (sram_req[b]),
      .sram_o        (sram[b])
    );

    for (genvar s = 0; s < `MI_SUB_BANKS; s++) begin : gen_sub
      sram_bank u_sram_bank (
        .clk_i,
        .rst_ni,
        .req_i   (sram_req[b][s]),
        .bank_i  (sram[b][s]),
        .rdata_o (sram_rdata[b][s])
      );
    end
  end

endmodule

// File: testbench/tb_mem_island.sv
/*
 * Memory island testbench
 * Table-driven narrow and wide accesses checked against a byte-level reference
 */

module tb_mem_island;
  timeunit 1ns;
  timeprecision 1ps;

  import mem_island_types_pkg::*;
  import mem_island_bus_pkg::*;

  localparam int Timeout = 20;

  typedef struct {
    bit         is_wide;
    bit         we;
    addr_t      addr;
    wide_data_t wdata;
    wide_strb_t strb;
    bit         rnd;
    bit         pair;
  } step_t;

  logic         clk_i;
  logic         rst_ni;
  logic         narrow_req_i;
  narrow_req_t  narrow_i;
  logic         narrow_gnt_o;
  logic         narrow_rvalid_o;
  narrow_data_t narrow_rdata_o;
  logic         wide_req_i;
  wide_req_t    wide_i;
  logic         wide_gnt_o;
  logic         wide_rvalid_o;
  wide_data_t   wide_rdata_o;

  logic [7:0] ref_mem [1024];
  step_t      steps [$];
  int         seed = 32'h702e;
  int         value_errors = 0;
  int         timeouts = 0;

  mem_island_top u_mem_island_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic step_t make_step(bit is_wide, bit we, addr_t addr, wide_data_t wdata,
                                      wide_strb_t strb, bit rnd, bit pair);
    step_t s;
    s = '{is_wide, we, addr, wdata, strb, rnd, pair};
    return s;
  endfunction

  // Bytes sit at their own address, so sub-bank 0 holds the low half of a wide word
  function automatic wide_data_t ref_read(step_t s);
    wide_data_t d;
    int         n;
    int         base;
    n    = s.is_wide ? 8 : 4;
    base = int'(s.addr[9:0]) & ~(n - 1);
    d    = '0;
    for (int i = 0; i < n; i++) begin
      d[8*i +: 8] = ref_mem[base + i];
    end
    return d;
  endfunction

  task automatic ref_write(step_t s);
    int n;
    int base;
    n    = s.is_wide ? 8 : 4;
    base = int'(s.addr[9:0]) & ~(n - 1);
    for (int i = 0; i < n; i++) begin
      if (s.strb[i]) ref_mem[base + i] = s.wdata[8*i +: 8];
    end
  endtask

  function automatic logic port_gnt(bit w);
    return w ? wide_gnt_o : narrow_gnt_o;
  endfunction

  function automatic logic port_rvalid(bit w);
    return w ? wide_rvalid_o : narrow_rvalid_o;
  endfunction

  task automatic drive_req(step_t s, logic on);
    if (s.is_wide) begin
      wide_req_i = on;
      wide_i     = '{addr: s.addr, we: s.we, wdata: s.wdata, strb: s.strb};
    end else begin
      narrow_req_i = on;
      narrow_i     = '{addr: s.addr, we: s.we, wdata: s.wdata[31:0], strb: s.strb[3:0]};
    end
  endtask

  // Grant is sampled on the rising edge, the response on the falling edge after it
  task automatic run_access(input step_t s, input wide_data_t exp, input int exp_wait);
    int    gnt_wait;
    int    rv_wait;
    string tag;
    tag = s.is_wide ? "wide" : "narrow";
    for (gnt_wait = 0; gnt_wait < Timeout; gnt_wait++) begin
      @(posedge clk_i);
      if (port_gnt(s.is_wide)) break;
    end
    @(negedge clk_i);
    drive_req(s, 1'b0);
    if (gnt_wait == Timeout) begin
      timeouts++;
      $display("Timeout: %s request to 0x%0h was never granted", tag, s.addr);
      return;
    end
    check_value({tag, "_gnt_o delay"}, 64'(gnt_wait), 64'(exp_wait));
    for (rv_wait = 1; rv_wait < Timeout && !port_rvalid(s.is_wide); rv_wait++) begin
      @(negedge clk_i);
    end
    if (!port_rvalid(s.is_wide)) begin
      timeouts++;
      $display("Timeout: %s response to 0x%0h never arrived", tag, s.addr);
    end else begin
      check_value({tag, "_rvalid_o delay"}, 64'(rv_wait), 64'd1);
      if (!s.we) begin
        check_value({tag, "_rdata_o"}, s.is_wide ? wide_rdata_o : 64'(narrow_rdata_o), exp);
      end
    end
  endtask

  initial begin
    step_t      a;
    step_t      b;
    wide_data_t exp_a;
    wide_data_t exp_b;
    int         idx;
    rst_ni       = 1'b0;
    narrow_req_i = 1'b0;
    wide_req_i   = 1'b0;
    narrow_i     = '0;
    wide_i       = '0;

    // Columns: wide, write, address, data, strobe, random data, paired with next row
    steps.push_back(make_step(0, 1, 16'h0010, 64'h0, 8'h0f, 1, 0));
    steps.push_back(make_step(0, 0, 16'h0010, 64'h0, 8'h00, 0, 0));
    steps.push_back(make_step(0, 1, 16'h0010, 64'haabbccdd, 8'h05, 0, 0));
    steps.push_back(make_step(0, 0, 16'h0010, 64'h0, 8'h00, 0, 0));
    steps.push_back(make_step(1, 1, 16'h0040, 64'h0, 8'hff, 1, 0));
    steps.push_back(make_step(0, 0, 16'h0040, 64'h0, 8'h00, 0, 0));
    steps.push_back(make_step(0, 0, 16'h0044, 64'h0, 8'h00, 0, 0));
    steps.push_back(make_step(0, 1, 16'h0058, 64'h0, 8'h0f, 1, 0));
    steps.push_back(make_step(0, 1, 16'h005c, 64'h0, 8'h0f, 1, 0));
    steps.push_back(make_step(1, 0, 16'h0058, 64'h0, 8'h00, 0, 0));
    steps.push_back(make_step(1, 1, 16'h0040, 64'h1122334455667788, 8'h3c, 0, 0));
    steps.push_back(make_step(1, 0, 16'h0040, 64'h0, 8'h00, 0, 0));
    // Same wide bank in one cycle
    steps.push_back(make_step(0, 1, 16'h0020, 64'h0, 8'h0f, 1, 1));
    steps.push_back(make_step(1, 1, 16'h0060, 64'h0, 8'hff, 1, 0));
    steps.push_back(make_step(0, 0, 16'h0020, 64'h0, 8'h00, 0, 1));
    steps.push_back(make_step(1, 0, 16'h0060, 64'h0, 8'h00, 0, 0));
    // Different wide banks in one cycle
    steps.push_back(make_step(0, 0, 16'h0040, 64'h0, 8'h00, 0, 1));
    steps.push_back(make_step(1, 0, 16'h0058, 64'h0, 8'h00, 0, 0));
    steps.push_back(make_step(0, 1, 16'h00a8, 64'h0, 8'h0f, 1, 1));
    steps.push_back(make_step(1, 1, 16'h00a0, 64'h0, 8'hff, 1, 0));
    steps.push_back(make_step(0, 0, 16'h00a8, 64'h0, 8'h00, 0, 0));
    steps.push_back(make_step(1, 0, 16'h00a0, 64'h0, 8'h00, 0, 0));

    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("narrow_rvalid_o", 64'(narrow_rvalid_o), 64'd0);
    check_value("wide_rvalid_o", 64'(wide_rvalid_o), 64'd0);

    idx = 0;
    while (idx < steps.size()) begin
      a = steps[idx];
      if (a.rnd) a.wdata = {$random(seed), $random(seed)};
      exp_a = ref_read(a);
      if (a.pair) begin
        // Paired rows are narrow then wide, the wide one waits a cycle on a shared bank
        b = steps[idx + 1];
        if (b.rnd) b.wdata = {$random(seed), $random(seed)};
        exp_b = ref_read(b);
        if (a.we) ref_write(a);
        if (b.we) ref_write(b);
        drive_req(a, 1'b1);
        drive_req(b, 1'b1);
        fork
          run_access(a, exp_a, 0);
          run_access(b, exp_b, (a.addr[3] == b.addr[3]) ? 1 : 0);
        join
        idx += 2;
      end else begin
        if (a.we) ref_write(a);
        drive_req(a, 1'b1);
        run_access(a, exp_a, 0);
        idx++;
      end
    end

    $display("Run complete: %0d value errors, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: mem_island.f
+incdir+source
source/mem_island_types_pkg.sv
source/mem_island_bus_pkg.sv
source/sram_bank.sv
source/bank_arbiter.sv
source/narrow_port.sv
source/wide_port.sv
source/mem_island_top.sv
testbench/tb_mem_island.sv

// File: Makefile
# Verilator build for the memory island testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_mem_island
FILELIST  := mem_island.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the verdict, the pipe status alone is not enough
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
